// ==== CpuPkg.sv ====
package CpuPkg;

    // Data and address words of the CPU bus
    typedef logic [7:0] byteT;
    typedef logic [15:0] addressT;

    // ALU operations selected by the sequencer
    typedef enum logic [3:0] {
        PassB,
        Add,
        Sub,
        And,
        Inc,
        Dec
    } aluOpT;

    // Address bus sources
    typedef enum logic [1:0] {
        ProgramCounter,
        OperandAddress,
        Vector
    } addrSelT;

    // Opcode values, same encodings as the 6502
    localparam byteT OpLdaImm = 8'hA9;
    localparam byteT OpLdaAbs = 8'hAD;
    localparam byteT OpStaAbs = 8'h8D;
    localparam byteT OpAdcImm = 8'h69;
    localparam byteT OpSbcImm = 8'hE9;
    localparam byteT OpAndImm = 8'h29;
    localparam byteT OpTax    = 8'hAA;
    localparam byteT OpTxa    = 8'h8A;
    localparam byteT OpInx    = 8'hE8;
    localparam byteT OpDex    = 8'hCA;
    localparam byteT OpJmpAbs = 8'h4C;
    localparam byteT OpBeq    = 8'hF0;
    localparam byteT OpBne    = 8'hD0;
    localparam byteT OpNop    = 8'hEA;

    // Low byte of the reset vector, high byte follows
    localparam addressT ResetVector = 16'hFFFC;

endpackage

// ==== CpuAlu.sv ====
module CpuAlu (
    input  CpuPkg::byteT  operandA,
    input  CpuPkg::byteT  operandB,
    input  logic          carryIn,
    input  CpuPkg::aluOpT operation,
    output CpuPkg::byteT  result,
    output logic          carryOut,
    output logic          overflowOut,
    output logic          zero,
    output logic          negative
);
    import CpuPkg::*;

    // Second adder input, inverted for subtraction
    byteT addend;
    // Nine bits so the carry out falls into the top bit
    logic [8:0] sum;

    always_comb begin
        // SBC is A + ~B + C, borrow is the inverted carry
        addend = (operation == Sub) ? ~operandB : operandB;
        sum = {1'b0, operandA} + {1'b0, addend} + {8'd0, carryIn};

        // Carry passes through for everything but the adder ops
        result = operandB;
        carryOut = carryIn;
        overflowOut = 1'b0;

        case (operation)
            Add, Sub: begin
                result = sum[7:0];
                carryOut = sum[8];
                // Signed overflow when both inputs agree in sign and the sum does not
                overflowOut = (operandA[7] == addend[7]) && (sum[7] != operandA[7]);
            end
            And: begin
                result = operandA & operandB;
            end
            Inc: begin
                result = operandA + 8'd1;
            end
            Dec: begin
                result = operandA - 8'd1;
            end
            default: begin
                result = operandB;
            end
        endcase
    end

    // N and Z come straight from the result
    assign zero = (result == 8'h00);
    assign negative = result[7];

endmodule

// ==== CpuSequencer.sv ====
module CpuSequencer (
    input  logic            clock,
    input  logic            reset,
    input  logic            enable,
    input  CpuPkg::byteT    opcode,
    input  logic            zeroFlag,
    output CpuPkg::addrSelT addrSel,
    output CpuPkg::aluOpT   aluOperation,
    output logic            loadOpcode,
    output logic            loadOperandLow,
    output logic            loadOperandHigh,
    output logic            loadA,
    output logic            loadX,
    output logic            loadPcFromOperand,
    output logic            incrementPc,
    output logic            branchTaken,
    output logic            storeCarryOverflow,
    output logic            storeNz,
    output logic            writeMemory,
    output logic            sync
);
    import CpuPkg::*;

    // One state per bus cycle of an instruction
    typedef enum logic [2:0] {
        VectorLow,
        VectorHigh,
        Fetch,
        Operand1,
        Operand2,
        Access,
        BranchAdd
    } stateT;

    stateT state;
    stateT nextState;

    // Opcode classes
    logic isImmediate;
    logic isAbsolute;
    logic isJump;
    logic isBranch;
    logic branchCondition;

    // Opcode comes from the bus during Fetch, from the opcode register after
    always_comb begin
        isImmediate = opcode inside {OpLdaImm, OpAdcImm, OpSbcImm, OpAndImm};
        isAbsolute = opcode inside {OpLdaAbs, OpStaAbs};
        isJump = (opcode == OpJmpAbs);
        isBranch = opcode inside {OpBeq, OpBne};
        // BEQ wants Z set, BNE wants it clear
        branchCondition = (opcode == OpBeq) ? zeroFlag : !zeroFlag;
    end

    // ALU operation only matters in cycles that store a result
    always_comb begin
        case (opcode)
            OpAdcImm: aluOperation = Add;
            OpSbcImm: aluOperation = Sub;
            OpAndImm: aluOperation = And;
            OpInx:    aluOperation = Inc;
            OpDex:    aluOperation = Dec;
            default:  aluOperation = PassB;
        endcase
    end

    // Address source, opcode latch and sync follow the state alone
    always_comb begin
        addrSel = ProgramCounter;
        loadOpcode = 1'b0;
        sync = 1'b0;
        case (state)
            VectorLow, VectorHigh: begin
                addrSel = Vector;
            end
            Fetch: begin
                loadOpcode = 1'b1;
                sync = 1'b1;
            end
            Access: begin
                addrSel = OperandAddress;
            end
            default: begin
                addrSel = ProgramCounter;
            end
        endcase
    end

    always_comb begin
        nextState = state;
        loadOperandLow = 1'b0;
        loadOperandHigh = 1'b0;
        loadA = 1'b0;
        loadX = 1'b0;
        loadPcFromOperand = 1'b0;
        incrementPc = 1'b0;
        branchTaken = 1'b0;
        storeCarryOverflow = 1'b0;
        storeNz = 1'b0;
        writeMemory = 1'b0;

        case (state)
            // Vector low byte parks in the operand register
            VectorLow: begin
                loadOperandLow = 1'b1;
                nextState = VectorHigh;
            end
            // High byte joins it straight into the PC
            VectorHigh: begin
                loadPcFromOperand = 1'b1;
                nextState = Fetch;
            end
            Fetch: begin
                incrementPc = 1'b1;
                nextState = Operand1;
            end
            Operand1: begin
                if (isImmediate) begin
                    // Immediate byte goes through the ALU into A
                    incrementPc = 1'b1;
                    loadA = 1'b1;
                    storeNz = 1'b1;
                    storeCarryOverflow = opcode inside {OpAdcImm, OpSbcImm};
                    nextState = Fetch;
                end else if (isAbsolute || isJump) begin
                    incrementPc = 1'b1;
                    loadOperandLow = 1'b1;
                    nextState = Operand2;
                end else if (isBranch) begin
                    // Offset is kept for the taken cycle
                    incrementPc = 1'b1;
                    loadOperandLow = 1'b1;
                    nextState = branchCondition ? BranchAdd : Fetch;
                end else begin
                    // Implied, with a dummy read of the next byte
                    // Unknown opcodes land here and store nothing
                    loadX = opcode inside {OpTax, OpInx, OpDex};
                    loadA = (opcode == OpTxa);
                    storeNz = loadX || loadA;
                    nextState = Fetch;
                end
            end
            Operand2: begin
                if (isJump) begin
                    loadPcFromOperand = 1'b1;
                    nextState = Fetch;
                end else begin
                    incrementPc = 1'b1;
                    loadOperandHigh = 1'b1;
                    nextState = Access;
                end
            end
            Access: begin
                if (opcode == OpStaAbs) begin
                    writeMemory = 1'b1;
                end else begin
                    loadA = 1'b1;
                    storeNz = 1'b1;
                end
                nextState = Fetch;
            end
            // PC plus offset, dummy read at the old PC
            BranchAdd: begin
                branchTaken = 1'b1;
                nextState = Fetch;
            end
            default: begin
                nextState = Fetch;
            end
        endcase
    end

    // State holds whenever the bus is stalled
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= VectorLow;
        end else if (enable) begin
            state <= nextState;
        end
    end

    // Store comes right after the high operand byte, so no stall inside STA
    assert property (@(posedge clock) disable iff (reset)
        writeMemory |-> (state == Access) && (opcode == OpStaAbs)
            && ($past(state) == Operand2));

    // An enabled fetch always moves on to an operand cycle
    assert property (@(posedge clock) disable iff (reset)
        (enable && sync) |=> !sync);

endmodule

// ==== Cpu6502Subset.sv ====
module Cpu6502Subset (
    input  logic            clock,
    input  logic            reset,
    input  logic            enable,
    input  CpuPkg::byteT    dataIn,
    output CpuPkg::byteT    dataOut,
    output logic            dataWriteEnable,
    output CpuPkg::addressT address,
    output logic            sync
);
    import CpuPkg::*;

    // Architectural and internal registers
    addressT programCounter;
    addressT operandAddress;
    byteT    opcodeReg;
    byteT    regA;
    byteT    regX;
    logic    flagN;
    logic    flagV;
    logic    flagZ;
    logic    flagC;
    // Selects the high vector byte once the low one is read
    logic    vectorHigh;

    // Sequencer controls
    addrSelT addrSel;
    aluOpT   aluOperation;
    logic    loadOpcode;
    logic    loadOperandLow;
    logic    loadOperandHigh;
    logic    loadA;
    logic    loadX;
    logic    loadPcFromOperand;
    logic    incrementPc;
    logic    branchTaken;
    logic    storeCarryOverflow;
    logic    storeNz;

    // Datapath nets
    byteT    currentOpcode;
    byteT    aluOperandA;
    byteT    aluOperandB;
    byteT    aluResult;
    logic    aluCarryOut;
    logic    aluOverflowOut;
    logic    aluZero;
    logic    aluNegative;
    addressT branchTarget;

    // Fetch decodes the byte on the bus, later cycles the latched one
    assign currentOpcode = loadOpcode ? dataIn : opcodeReg;

    CpuSequencer sequencer0 (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .opcode(currentOpcode),
        .zeroFlag(flagZ),
        .addrSel(addrSel),
        .aluOperation(aluOperation),
        .loadOpcode(loadOpcode),
        .loadOperandLow(loadOperandLow),
        .loadOperandHigh(loadOperandHigh),
        .loadA(loadA),
        .loadX(loadX),
        .loadPcFromOperand(loadPcFromOperand),
        .incrementPc(incrementPc),
        .branchTaken(branchTaken),
        .storeCarryOverflow(storeCarryOverflow),
        .storeNz(storeNz),
        .writeMemory(dataWriteEnable),
        .sync(sync)
    );

    // ALU inputs
    always_comb begin
        // INX and DEX count on X, everything else works on A
        aluOperandA = (opcodeReg == OpInx || opcodeReg == OpDex) ? regX : regA;
        case (opcodeReg)
            OpTxa:   aluOperandB = regX;
            OpTax:   aluOperandB = regA;
            default: aluOperandB = dataIn;
        endcase
    end

    CpuAlu alu0 (
        .operandA(aluOperandA),
        .operandB(aluOperandB),
        .carryIn(flagC),
        .operation(aluOperation),
        .result(aluResult),
        .carryOut(aluCarryOut),
        .overflowOut(aluOverflowOut),
        .zero(aluZero),
        .negative(aluNegative)
    );

    // Relative branch, offset sign extended to 16 bits
    assign branchTarget = programCounter
        + {{8{operandAddress[7]}}, operandAddress[7:0]};

    // Address bus
    always_comb begin
        case (addrSel)
            OperandAddress: address = operandAddress;
            Vector:         address = ResetVector + addressT'(vectorHigh);
            default:        address = programCounter;
        endcase
    end

    // Only A is ever stored
    assign dataOut = regA;

    // PC, opcode, flags and vector step
    always_ff @(posedge clock) begin
        if (reset) begin
            programCounter <= ResetVector;
            opcodeReg <= OpNop;
            vectorHigh <= 1'b0;
            flagN <= 1'b0;
            flagV <= 1'b0;
            flagZ <= 1'b0;
            flagC <= 1'b0;
        end else if (enable) begin
            if (addrSel == Vector) begin
                vectorHigh <= 1'b1;
            end
            // JMP and the vector both take the high byte from the bus
            if (loadPcFromOperand) begin
                programCounter <= {dataIn, operandAddress[7:0]};
            end else if (branchTaken) begin
                programCounter <= branchTarget;
            end else if (incrementPc) begin
                programCounter <= programCounter + 16'd1;
            end
            if (loadOpcode) begin
                opcodeReg <= dataIn;
            end
            if (storeNz) begin
                flagN <= aluNegative;
                flagZ <= aluZero;
            end
            if (storeCarryOverflow) begin
                flagC <= aluCarryOut;
                flagV <= aluOverflowOut;
            end
        end
    end

    // Operand bytes and data registers
    always_ff @(posedge clock) begin
        if (enable) begin
            if (loadOperandLow) begin
                operandAddress[7:0] <= dataIn;
            end
            if (loadOperandHigh) begin
                operandAddress[15:8] <= dataIn;
            end
            if (loadA) begin
                regA <= aluResult;
            end
            if (loadX) begin
                regX <= aluResult;
            end
        end
    end

    // Arbiter must never stall a store cycle
    assert property (@(posedge clock) disable iff (reset)
        dataWriteEnable |-> enable);

endmodule

// ==== BusArbiter.sv ====
module BusArbiter #(
    parameter int RamAddrWidth = 12
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    sync,
    input  CpuPkg::addressT         cpuAddress,
    input  CpuPkg::byteT            cpuDataOut,
    input  logic                    cpuWriteEnable,
    output logic                    cpuEnable,
    input  logic                    hostRequest,
    input  logic                    hostWrite,
    input  CpuPkg::addressT         hostAddress,
    input  CpuPkg::byteT            hostWriteData,
    output logic                    hostGrant,
    output logic [RamAddrWidth-1:0] ramAddress,
    output CpuPkg::byteT            ramWriteData,
    output logic                    ramWriteEnable
);

    typedef enum logic {
        CpuOwns,
        HostOwns
    } ownerT;

    ownerT owner;

    // Host gets the RAM during reset, at an opcode fetch, or while it already owns it
    assign hostGrant = hostRequest && (reset || sync || owner == HostOwns);

    // CPU stalls in the granted fetch, resumes as soon as the request drops
    assign cpuEnable = (owner == HostOwns) ? !hostRequest
                                           : !(hostRequest && (sync || reset));

    always_ff @(posedge clock) begin
        if (reset) begin
            owner <= CpuOwns;
        end else if (owner == CpuOwns && hostGrant) begin
            owner <= HostOwns;
        end else if (owner == HostOwns && !hostRequest) begin
            owner <= CpuOwns;
        end
    end

    // RAM port follows the owner, address wraps to the RAM size
    assign ramAddress = hostGrant ? hostAddress[RamAddrWidth-1:0]
                                  : cpuAddress[RamAddrWidth-1:0];
    assign ramWriteData = hostGrant ? hostWriteData : cpuDataOut;
    assign ramWriteEnable = hostGrant ? hostWrite : (cpuWriteEnable && cpuEnable);

    // Exactly one side sees the RAM in any cycle
    assert property (@(posedge clock) !(cpuEnable && hostGrant));

endmodule

// ==== SystemRam.sv ====
module SystemRam #(
    parameter int RamAddrWidth = 12
) (
    input  logic                    clock,
    input  logic [RamAddrWidth-1:0] address,
    input  CpuPkg::byteT            writeData,
    input  logic                    writeEnable,
    output CpuPkg::byteT            readData
);
    import CpuPkg::*;

    byteT memory [0:(1 << RamAddrWidth) - 1];

    // Write commits at the edge ending the cycle
    always_ff @(posedge clock) begin
        if (writeEnable) begin
            memory[address] <= writeData;
        end
    end

    // Read data is valid in the same cycle as its address
    assign readData = memory[address];

endmodule

// ==== CpuSystem.sv ====
module CpuSystem #(
    parameter int RamAddrWidth = 12
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            hostRequest,
    input  logic            hostWrite,
    input  CpuPkg::addressT hostAddress,
    input  CpuPkg::byteT    hostWriteData,
    output CpuPkg::byteT    hostReadData,
    output logic            hostGrant,
    output CpuPkg::addressT address,
    output logic            sync
);
    import CpuPkg::*;

    // CPU side of the arbiter
    byteT cpuDataOut;
    logic cpuWriteEnable;
    logic cpuEnable;

    // RAM port
    logic [RamAddrWidth-1:0] ramAddress;
    byteT                    ramWriteData;
    logic                    ramWriteEnable;

    // RAM read data is shared by the CPU and the host
    Cpu6502Subset cpu0 (
        .clock(clock),
        .reset(reset),
        .enable(cpuEnable),
        .dataIn(hostReadData),
        .dataOut(cpuDataOut),
        .dataWriteEnable(cpuWriteEnable),
        .address(address),
        .sync(sync)
    );

    BusArbiter #(
        .RamAddrWidth(RamAddrWidth)
    ) arbiter0 (
        .clock(clock),
        .reset(reset),
        .sync(sync),
        .cpuAddress(address),
        .cpuDataOut(cpuDataOut),
        .cpuWriteEnable(cpuWriteEnable),
        .cpuEnable(cpuEnable),
        .hostRequest(hostRequest),
        .hostWrite(hostWrite),
        .hostAddress(hostAddress),
        .hostWriteData(hostWriteData),
        .hostGrant(hostGrant),
        .ramAddress(ramAddress),
        .ramWriteData(ramWriteData),
        .ramWriteEnable(ramWriteEnable)
    );

    SystemRam #(
        .RamAddrWidth(RamAddrWidth)
    ) ram0 (
        .clock(clock),
        .address(ramAddress),
        .writeData(ramWriteData),
        .writeEnable(ramWriteEnable),
        .readData(hostReadData)
    );

endmodule

// ==== CpuSystemTb.sv ====
module CpuSystemTb;
    import CpuPkg::*;

    logic    clock;
    logic    reset;
    logic    hostRequest;
    logic    hostWrite;
    addressT hostAddress;
    byteT    hostWriteData;
    byteT    hostReadData;
    logic    hostGrant;
    addressT address;
    logic    sync;

    // Check channel sampled by the result assertion
    logic        checkValid;
    logic [15:0] checkObserved;
    logic [15:0] checkExpected;
    string       checkLabel;

    int   errorCount;
    int   testsPassed;
    int   testsFailed;
    int   seed;
    byteT programBytes[$];

    CpuSystem #(
        .RamAddrWidth(12)
    ) dut0 (
        .clock(clock),
        .reset(reset),
        .hostRequest(hostRequest),
        .hostWrite(hostWrite),
        .hostAddress(hostAddress),
        .hostWriteData(hostWriteData),
        .hostReadData(hostReadData),
        .hostGrant(hostGrant),
        .address(address),
        .sync(sync)
    );

    always #10 clock = ~clock;

    // Result compare against the testbench model
    assert property (@(posedge clock) checkValid |-> checkObserved == checkExpected)
    else begin
        errorCount++;
        $display("ERROR at time %0t: %s observed %h expected %h", $time, checkLabel,
            checkObserved, checkExpected);
    end

    // Host may only take over at an opcode fetch
    assert property (@(posedge clock) disable iff (reset) $rose(hostGrant) |-> sync)
    else begin
        errorCount++;
        $display("Host grant rose outside an opcode fetch cycle at time %0t", $time);
    end

    // CPU bus is frozen while the host owns the RAM
    assert property (@(posedge clock) disable iff (reset)
        (hostGrant && $past(hostGrant)) |-> $stable(address))
    else begin
        errorCount++;
        $display("CPU address moved while the host owned the RAM at time %0t", $time);
    end

    task automatic abortRun(input string reason);
        $display("Timeout while waiting for %s at time %0t", reason, $time);
        $display("Simulation failed");
        $finish;
    endtask

    // One granted host transfer, request is left high for back-to-back use
    task automatic hostTransfer(input logic write, input addressT addr, input byteT data,
                                output byteT readData);
        int waited;
        waited = 0;
        hostRequest <= 1'b1;
        hostWrite <= write;
        hostAddress <= addr;
        hostWriteData <= data;
        forever begin
            @(negedge clock);
            if (hostGrant) begin
                break;
            end
            waited++;
            if (waited > 50) begin
                abortRun("host grant");
            end
        end
        readData = hostReadData;
        @(posedge clock);
    endtask

    task automatic hostRelease();
        hostRequest <= 1'b0;
        hostWrite <= 1'b0;
    endtask

    task automatic writeByte(input addressT addr, input byteT data);
        byteT unused;
        hostTransfer(1'b1, addr, data, unused);
    endtask

    // Counts cycles up to and including the next sync cycle
    task automatic waitForSync(output int cycles, output addressT fetchAddress);
        cycles = 0;
        forever begin
            @(negedge clock);
            cycles++;
            if (sync) begin
                fetchAddress = address;
                break;
            end
            if (cycles > 20) begin
                abortRun("an opcode fetch");
            end
        end
        @(posedge clock);
    endtask

    // Waits until the CPU fetches at the self-loop address
    task automatic waitForSyncAt(input addressT addr);
        int waited;
        waited = 0;
        forever begin
            @(negedge clock);
            if (sync && address == addr) begin
                break;
            end
            waited++;
            if (waited > 3000) begin
                abortRun("the end of the program");
            end
        end
        @(posedge clock);
    endtask

    // Reset, load program at 0200 with its vector, leave reset high
    task automatic loadProgram();
        reset <= 1'b1;
        repeat (8) @(posedge clock);
        foreach (programBytes[i]) begin
            writeByte(16'h0200 + addressT'(i), programBytes[i]);
        end
        writeByte(ResetVector, 8'h00);
        writeByte(ResetVector + 16'd1, 8'h02);
    endtask

    task automatic releaseReset();
        hostRelease();
        reset <= 1'b0;
    endtask

    task automatic checkValue(input string label, input logic [15:0] observed,
                              input logic [15:0] expected);
        checkLabel = label;
        checkObserved <= observed;
        checkExpected <= expected;
        checkValid <= 1'b1;
        @(posedge clock);
        checkValid <= 1'b0;
        @(posedge clock);
    endtask

    task automatic readAndCheck(input string label, input addressT addr, input byteT expected);
        byteT data;
        hostTransfer(1'b0, addr, 8'h00, data);
        hostRelease();
        @(posedge clock);
        checkValue(label, {8'h00, data}, {8'h00, expected});
    endtask

    task automatic reportTest(input string name, input int startErrors);
        if (errorCount == startErrors) begin
            testsPassed++;
            $display("Test %s: pass", name);
        end else begin
            testsFailed++;
            $display("Test %s: FAIL (%0d errors)", name, errorCount - startErrors);
        end
    endtask

    // 6502 binary result with carry clear
    function automatic byteT arithModel(input int sel, input byteT a, input byteT b);
        case (sel)
            0: return a + b;
            // Clear carry means SBC borrows one extra
            1: return a - b - 8'd1;
            default: return a & b;
        endcase
    endfunction

    initial begin
        int      startErrors;
        int      cycles;
        int      firstCycles;
        addressT firstAddress;
        addressT syncAddress;
        int      sel;
        int      count;
        byteT    a;
        byteT    b;
        byteT    expected;
        byteT    opcode;
        logic [8:0] sum;
        logic    carry;
        int      gaps[$];
        int      measured[$];

        clock = 1'b0;
        reset <= 1'b1;
        hostRequest <= 1'b0;
        hostWrite <= 1'b0;
        hostAddress <= '0;
        hostWriteData <= '0;
        checkValid <= 1'b0;
        checkObserved <= '0;
        checkExpected <= '0;
        errorCount = 0;
        testsPassed = 0;
        testsFailed = 0;
        seed = 7638;
        @(posedge clock);

        // Vector fetch and opcode timing, 02 is an unknown opcode
        programBytes = '{OpLdaImm, 8'h01, OpNop, OpTax, OpInx, 8'h02,
            OpLdaAbs, 8'h00, 8'h03, OpStaAbs, 8'h01, 8'h03, OpBne, 8'h00,
            OpBeq, 8'h00, OpJmpAbs, 8'h13, 8'h02, OpJmpAbs, 8'h13, 8'h02};
        gaps = '{2, 2, 2, 2, 2, 4, 4, 3, 2, 3, 3};
        startErrors = errorCount;
        loadProgram();
        // Nonzero so BNE is taken
        writeByte(16'h0300, 8'h55);
        releaseReset();
        waitForSync(firstCycles, firstAddress);
        // Gaps are measured back to back, checks come after
        foreach (gaps[i]) begin
            waitForSync(cycles, syncAddress);
            measured.push_back(cycles);
        end
        checkValue("first sync cycle", 16'(firstCycles), 16'd3);
        checkValue("first fetch address", firstAddress, 16'h0200);
        reportTest("reset vector", startErrors);

        startErrors = errorCount;
        foreach (gaps[i]) begin
            checkValue($sformatf("sync gap %0d", i), 16'(measured[i]), 16'(gaps[i]));
        end
        readAndCheck("stored byte", 16'h0301, 8'h55);
        reportTest("instruction timing", startErrors);

        // Immediate arithmetic with carry clear
        for (int t = 0; t < 4; t++) begin
            a = byteT'($random(seed));
            b = byteT'($random(seed));
            sel = {$random(seed)} % 3;
            opcode = (sel == 0) ? OpAdcImm : (sel == 1) ? OpSbcImm : OpAndImm;
            expected = arithModel(sel, a, b);
            programBytes = '{OpLdaImm, a, opcode, b, OpStaAbs, 8'h00, 8'h03,
                OpJmpAbs, 8'h07, 8'h02};
            startErrors = errorCount;
            loadProgram();
            releaseReset();
            waitForSyncAt(16'h0207);
            readAndCheck("arithmetic result", 16'h0300, expected);
            reportTest($sformatf("arithmetic %0d", t), startErrors);
        end

        // Memory accumulator counted down by X
        for (int t = 0; t < 2; t++) begin
            count = ({$random(seed)} % 20) + 1;
            b = byteT'($random(seed));
            programBytes = '{OpLdaImm, byteT'(count), OpTax, OpLdaImm, 8'h00,
                OpStaAbs, 8'h00, 8'h03, OpLdaAbs, 8'h00, 8'h03, OpAdcImm, b,
                OpStaAbs, 8'h00, 8'h03, OpDex, OpBne, 8'hF5, OpTxa,
                OpStaAbs, 8'h01, 8'h03, OpJmpAbs, 8'h17, 8'h02};
            expected = 8'h00;
            carry = 1'b0;
            for (int i = 0; i < count; i++) begin
                sum = {1'b0, expected} + {1'b0, b} + {8'd0, carry};
                expected = sum[7:0];
                carry = sum[8];
            end
            startErrors = errorCount;
            loadProgram();
            releaseReset();
            waitForSyncAt(16'h0217);
            readAndCheck("loop sum", 16'h0300, expected);
            readAndCheck("final X", 16'h0301, 8'h00);
            reportTest($sformatf("loop %0d", t), startErrors);
        end

        // Host writes the operand while the CPU counts down
        a = byteT'($random(seed));
        programBytes = '{OpLdaImm, 8'h28, OpTax, OpDex, OpBne, 8'hFD,
            OpLdaAbs, 8'h00, 8'h03, OpStaAbs, 8'h01, 8'h03, OpJmpAbs, 8'h0C, 8'h02};
        startErrors = errorCount;
        loadProgram();
        writeByte(16'h0300, 8'h11);
        releaseReset();
        repeat (10) @(posedge clock);
        writeByte(16'h0300, a);
        hostTransfer(1'b0, 16'h0300, 8'h00, b);
        hostRelease();
        @(posedge clock);
        checkValue("host readback", {8'h00, b}, {8'h00, a});
        waitForSyncAt(16'h020C);
        readAndCheck("value loaded by CPU", 16'h0301, a);
        reportTest("host access", startErrors);

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
            testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== CpuSystem.f ====
CpuPkg.sv
CpuAlu.sv
CpuSequencer.sv
Cpu6502Subset.sv
BusArbiter.sv
SystemRam.sv
CpuSystem.sv
CpuSystemTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= CpuSystemTb
FILELIST  ?= CpuSystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Test FAILED"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Test FAILED, run ended early"; exit 1; \
	else \
		echo "Test PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
